// ==== source/axil_iob_defs.svh ====
`ifndef AXIL_IOB_DEFS_SVH
`define AXIL_IOB_DEFS_SVH

// Bus widths, shared by the AXI4-Lite and IOb sides
`define AXIL_IOB_ADDR_W 12
`define AXIL_IOB_DATA_W 32

// Address map
// Bit 11 high selects the RAM, low selects the CSR bank
`define AXIL_IOB_RAM_SEL_BIT 11
`define AXIL_IOB_RAM_AW 8

// Identification value
`define AXIL_IOB_ID 32'hA51C_0001

// CSR byte offsets
`define AXIL_IOB_CSR_ID 12'h000
`define AXIL_IOB_CSR_SCR0 12'h004
`define AXIL_IOB_CSR_SCR1 12'h008
`define AXIL_IOB_CSR_CYCLE 12'h00C

`endif

// ==== source/axil_pkg.sv ====
`include "axil_iob_defs.svh"

package axil_pkg;

  typedef logic [`AXIL_IOB_ADDR_W-1:0] axil_addr_t;
  typedef logic [`AXIL_IOB_DATA_W-1:0] axil_data_t;
  typedef logic [`AXIL_IOB_DATA_W/8-1:0] axil_strb_t;
  typedef logic [1:0] axil_resp_t;

  // Master to slave, write side (aw, w and b channels)
  typedef struct packed {
    logic       awvalid;
    axil_addr_t awaddr;
    logic       wvalid;
    axil_data_t wdata;
    axil_strb_t wstrb;
    logic       bready;
  } axil_wr_req_t;

  // Master to slave, read side
  typedef struct packed {
    logic       arvalid;
    axil_addr_t araddr;
    logic       rready;
  } axil_rd_req_t;

  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    axil_resp_t bresp;
  } axil_wr_rsp_t;

  typedef struct packed {
    logic       arready;
    logic       rvalid;
    axil_data_t rdata;
    axil_resp_t rresp;
  } axil_rd_rsp_t;

endpackage

// ==== source/iob_pkg.sv ====
`include "axil_iob_defs.svh"

package iob_pkg;

  typedef logic [`AXIL_IOB_ADDR_W-1:0] iob_addr_t;
  typedef logic [`AXIL_IOB_DATA_W-1:0] iob_data_t;
  typedef logic [`AXIL_IOB_DATA_W/8-1:0] iob_strb_t;

  // Zero wstrb marks a read
  typedef struct packed {
    logic      avalid;
    iob_addr_t addr;
    iob_data_t wdata;
    iob_strb_t wstrb;
  } iob_req_t;

  typedef struct packed {
    logic      ready;
    logic      rvalid;
    iob_data_t rdata;
  } iob_rsp_t;

  // Byte lane merge used by every writable target
  function automatic iob_data_t iob_merge(iob_data_t old_d, iob_data_t new_d,
                                          iob_strb_t strb);
    iob_data_t res;
    res = old_d;
    for (int i = 0; i < $bits(iob_strb_t); i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_d[8*i +: 8];
      end
    end
    return res;
  endfunction

endpackage

// ==== source/axil2iob.sv ====
module axil2iob (
  input  logic                   clk_i,
  input  logic                   cke_i,
  input  logic                   arst_n_i,
  input  axil_pkg::axil_wr_req_t axil_wr_i,
  input  axil_pkg::axil_rd_req_t axil_rd_i,
  output axil_pkg::axil_wr_rsp_t axil_wr_o,
  output axil_pkg::axil_rd_rsp_t axil_rd_o,
  output iob_pkg::iob_req_t      iob_req_o,
  input  iob_pkg::iob_rsp_t      iob_rsp_i
);

  logic                 wr_ready;
  logic                 wr_evt;
  logic                 bvalid_q;
  logic                 bvalid_nxt;
  logic                 rvalid_q;
  logic                 rvalid_nxt;
  axil_pkg::axil_data_t rdata_q;

  // Read has priority, a colliding write just waits
  assign wr_ready = iob_rsp_i.ready & ~axil_rd_i.arvalid;
  assign wr_evt   = axil_wr_i.awvalid & axil_wr_i.wvalid & wr_ready;

  // Toggle on a new write, or on bready with no new write
  assign bvalid_nxt = bvalid_q ^ ((~bvalid_q & wr_evt) |
                                  (bvalid_q & axil_wr_i.bready & ~wr_evt));

  // Same scheme for reads, driven by the returning IOb rvalid
  assign rvalid_nxt = rvalid_q ^ ((~rvalid_q & iob_rsp_i.rvalid) |
                                  (rvalid_q & axil_rd_i.rready & ~iob_rsp_i.rvalid));

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
    end else if (cke_i) begin
      bvalid_q <= bvalid_nxt;
      rvalid_q <= rvalid_nxt;
      if (iob_rsp_i.rvalid) begin
        rdata_q <= iob_rsp_i.rdata;
      end
    end
  end

  // Write response channel
  assign axil_wr_o.awready = wr_ready;
  assign axil_wr_o.wready  = wr_ready;
  assign axil_wr_o.bvalid  = bvalid_q;
  assign axil_wr_o.bresp   = 2'b00;

  // Read response channel, always OKAY
  assign axil_rd_o.arready = iob_rsp_i.ready;
  assign axil_rd_o.rvalid  = rvalid_q;
  assign axil_rd_o.rdata   = rdata_q;
  assign axil_rd_o.rresp   = 2'b00;

  // IOb request
  // Zero-strobe writes are acked above but never reach a target
  assign iob_req_o.avalid = (axil_wr_i.wvalid & |axil_wr_i.wstrb) | axil_rd_i.arvalid;
  assign iob_req_o.addr   = axil_rd_i.arvalid ? axil_rd_i.araddr : axil_wr_i.awaddr;
  assign iob_req_o.wdata  = axil_wr_i.wdata;
  assign iob_req_o.wstrb  = axil_rd_i.arvalid ? '0 : axil_wr_i.wstrb;

endmodule

// ==== source/iob_decoder.sv ====
`include "axil_iob_defs.svh"

module iob_decoder (
  input  logic              clk_i,
  input  logic              cke_i,
  input  logic              arst_n_i,
  input  iob_pkg::iob_req_t req_i,
  output iob_pkg::iob_rsp_t rsp_o,
  output iob_pkg::iob_req_t csr_req_o,
  output iob_pkg::iob_req_t ram_req_o,
  input  iob_pkg::iob_rsp_t csr_rsp_i,
  input  iob_pkg::iob_rsp_t ram_rsp_i
);

  logic ram_sel;
  logic ram_sel_q;
  logic ready;
  logic rd_acc;

  assign ram_sel = req_i.addr[`AXIL_IOB_RAM_SEL_BIT];
  assign ready   = ram_sel ? ram_rsp_i.ready : csr_rsp_i.ready;

  // Only avalid is steered, the rest fans out to both targets
  always_comb begin
    csr_req_o        = req_i;
    ram_req_o        = req_i;
    csr_req_o.avalid = req_i.avalid & ~ram_sel;
    ram_req_o.avalid = req_i.avalid & ram_sel;
  end

  assign rd_acc = req_i.avalid & ready & ~|req_i.wstrb;

  // Target of the read in flight
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ram_sel_q <= 1'b0;
    end else if (cke_i && rd_acc) begin
      ram_sel_q <= ram_sel;
    end
  end

  assign rsp_o.ready  = ready;
  assign rsp_o.rvalid = ram_sel_q ? ram_rsp_i.rvalid : csr_rsp_i.rvalid;
  assign rsp_o.rdata  = ram_sel_q ? ram_rsp_i.rdata : csr_rsp_i.rdata;

endmodule

// ==== source/iob_csr_bank.sv ====
`include "axil_iob_defs.svh"

module iob_csr_bank (
  input  logic              clk_i,
  input  logic              cke_i,
  input  logic              arst_n_i,
  input  iob_pkg::iob_req_t req_i,
  output iob_pkg::iob_rsp_t rsp_o
);

  iob_pkg::iob_addr_t reg_addr;
  logic               wr_en;
  logic               rd_en;
  iob_pkg::iob_data_t scr0_q;
  iob_pkg::iob_data_t scr1_q;
  iob_pkg::iob_data_t cycle_q;
  iob_pkg::iob_data_t rd_val;
  iob_pkg::iob_data_t rdata_q;
  logic               rvalid_q;

  // Word aligned offset
  assign reg_addr = {req_i.addr[`AXIL_IOB_ADDR_W-1:2], 2'b00};

  assign wr_en = req_i.avalid & |req_i.wstrb;
  assign rd_en = req_i.avalid & ~|req_i.wstrb;

  // Scratch registers and free-running counter
  // ID and counter ignore writes
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      scr0_q   <= '0;
      scr1_q   <= '0;
      cycle_q  <= '0;
      rvalid_q <= 1'b0;
    end else if (cke_i) begin
      cycle_q  <= cycle_q + 1'b1;
      rvalid_q <= rd_en;
      if (wr_en && reg_addr == `AXIL_IOB_CSR_SCR0) begin
        scr0_q <= iob_pkg::iob_merge(scr0_q, req_i.wdata, req_i.wstrb);
      end
      if (wr_en && reg_addr == `AXIL_IOB_CSR_SCR1) begin
        scr1_q <= iob_pkg::iob_merge(scr1_q, req_i.wdata, req_i.wstrb);
      end
    end
  end

  // Read mux, unmapped offsets give zero
  always_comb begin
    case (reg_addr)
      `AXIL_IOB_CSR_ID:    rd_val = `AXIL_IOB_ID;
      `AXIL_IOB_CSR_SCR0:  rd_val = scr0_q;
      `AXIL_IOB_CSR_SCR1:  rd_val = scr1_q;
      `AXIL_IOB_CSR_CYCLE: rd_val = cycle_q;
      default:             rd_val = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (cke_i && rd_en) begin
      rdata_q <= rd_val;
    end
  end

  // Always ready, one-cycle read latency
  assign rsp_o.ready  = 1'b1;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;

endmodule

// ==== source/iob_ram.sv ====
`include "axil_iob_defs.svh"

module iob_ram #(
  parameter int ADDR_W = `AXIL_IOB_RAM_AW
) (
  input  logic              clk_i,
  input  logic              cke_i,
  input  logic              arst_n_i,
  input  iob_pkg::iob_req_t req_i,
  output iob_pkg::iob_rsp_t rsp_o
);

  iob_pkg::iob_data_t mem [2**ADDR_W];
  logic [ADDR_W-1:0]  word_addr;
  logic               wr_en;
  logic               rd_en;
  iob_pkg::iob_data_t rdata_q;
  logic               rvalid_q;

  // Byte address to word index
  assign word_addr = req_i.addr[ADDR_W+1:2];
  assign wr_en     = req_i.avalid & |req_i.wstrb;
  assign rd_en     = req_i.avalid & ~|req_i.wstrb;

  always_ff @(posedge clk_i) begin
    if (cke_i) begin
      if (wr_en) begin
        mem[word_addr] <= iob_pkg::iob_merge(mem[word_addr], req_i.wdata, req_i.wstrb);
      end
      if (rd_en) begin
        rdata_q <= mem[word_addr];
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else if (cke_i) begin
      rvalid_q <= rd_en;
    end
  end

  assign rsp_o.ready  = 1'b1;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;

endmodule

// ==== source/axil_iob_top.sv ====
`include "axil_iob_defs.svh"

module axil_iob_top (
  input  logic                 clk_i,
  input  logic                 cke_i,
  input  logic                 arst_n_i,
  // AXI4-Lite slave
  input  logic                 axil_awvalid_i,
  input  axil_pkg::axil_addr_t axil_awaddr_i,
  input  logic                 axil_wvalid_i,
  input  axil_pkg::axil_data_t axil_wdata_i,
  input  axil_pkg::axil_strb_t axil_wstrb_i,
  input  logic                 axil_bready_i,
  input  logic                 axil_arvalid_i,
  input  axil_pkg::axil_addr_t axil_araddr_i,
  input  logic                 axil_rready_i,
  output logic                 axil_awready_o,
  output logic                 axil_wready_o,
  output logic                 axil_bvalid_o,
  output axil_pkg::axil_resp_t axil_bresp_o,
  output logic                 axil_arready_o,
  output logic                 axil_rvalid_o,
  output axil_pkg::axil_data_t axil_rdata_o,
  output axil_pkg::axil_resp_t axil_rresp_o
);

  axil_pkg::axil_wr_req_t axil_wr_req;
  axil_pkg::axil_rd_req_t axil_rd_req;
  axil_pkg::axil_wr_rsp_t axil_wr_rsp;
  axil_pkg::axil_rd_rsp_t axil_rd_rsp;
  iob_pkg::iob_req_t      iob_req;
  iob_pkg::iob_rsp_t      iob_rsp;
  iob_pkg::iob_req_t      csr_req;
  iob_pkg::iob_rsp_t      csr_rsp;
  iob_pkg::iob_req_t      ram_req;
  iob_pkg::iob_rsp_t      ram_rsp;

  // Pack flat AXI ports
  assign axil_wr_req = '{awvalid: axil_awvalid_i, awaddr: axil_awaddr_i,
                         wvalid: axil_wvalid_i, wdata: axil_wdata_i,
                         wstrb: axil_wstrb_i, bready: axil_bready_i};
  assign axil_rd_req = '{arvalid: axil_arvalid_i, araddr: axil_araddr_i,
                         rready: axil_rready_i};

  assign axil_awready_o = axil_wr_rsp.awready;
  assign axil_wready_o  = axil_wr_rsp.wready;
  assign axil_bvalid_o  = axil_wr_rsp.bvalid;
  assign axil_bresp_o   = axil_wr_rsp.bresp;
  assign axil_arready_o = axil_rd_rsp.arready;
  assign axil_rvalid_o  = axil_rd_rsp.rvalid;
  assign axil_rdata_o   = axil_rd_rsp.rdata;
  assign axil_rresp_o   = axil_rd_rsp.rresp;

  axil2iob bridge0 (
    .clk_i    (clk_i),
    .cke_i    (cke_i),
    .arst_n_i (arst_n_i),
    .axil_wr_i(axil_wr_req),
    .axil_rd_i(axil_rd_req),
    .axil_wr_o(axil_wr_rsp),
    .axil_rd_o(axil_rd_rsp),
    .iob_req_o(iob_req),
    .iob_rsp_i(iob_rsp)
  );

  iob_decoder dec0 (
    .clk_i    (clk_i),
    .cke_i    (cke_i),
    .arst_n_i (arst_n_i),
    .req_i    (iob_req),
    .rsp_o    (iob_rsp),
    .csr_req_o(csr_req),
    .ram_req_o(ram_req),
    .csr_rsp_i(csr_rsp),
    .ram_rsp_i(ram_rsp)
  );

  iob_csr_bank csr0 (
    .clk_i   (clk_i),
    .cke_i   (cke_i),
    .arst_n_i(arst_n_i),
    .req_i   (csr_req),
    .rsp_o   (csr_rsp)
  );

  iob_ram #(
    .ADDR_W(`AXIL_IOB_RAM_AW)
  ) ram0 (
    .clk_i   (clk_i),
    .cke_i   (cke_i),
    .arst_n_i(arst_n_i),
    .req_i   (ram_req),
    .rsp_o   (ram_rsp)
  );

endmodule

// ==== sim/axil_iob_tb.sv ====
`include "axil_iob_defs.svh"

module axil_iob_tb;

  localparam int unsigned SEED = 32'h88ef_6106;
  // Transactions per test are 1 + 34 + 196 + 6 + 16 + 6
  localparam int TXN_CNT    = 259;
  localparam int MAX_CYCLES = 4 * TXN_CNT * 6;

  logic                 clk;
  logic                 cke;
  logic                 arst_n;
  logic                 awvalid;
  axil_pkg::axil_addr_t awaddr;
  logic                 wvalid;
  axil_pkg::axil_data_t wdata;
  axil_pkg::axil_strb_t wstrb;
  logic                 bready;
  logic                 arvalid;
  axil_pkg::axil_addr_t araddr;
  logic                 rready;
  logic                 awready;
  logic                 wready;
  logic                 bvalid;
  axil_pkg::axil_resp_t bresp;
  logic                 arready;
  logic                 rvalid;
  axil_pkg::axil_data_t rdata;
  axil_pkg::axil_resp_t rresp;

  // Expected read data and compare mode for the cycle counter
  axil_pkg::axil_data_t exp_rdata;
  logic                 cmp_gt;
  axil_pkg::axil_data_t rdata_now;
  axil_pkg::axil_data_t rdata_prev;
  axil_pkg::axil_data_t scr_model [2];
  axil_pkg::axil_data_t ram_model [256];
  int                   err_cnt;
  int                   tests_run;
  int                   tests_bad;
  int                   cycle_cnt;

  axil_iob_top dut0 (
    .clk_i         (clk),
    .cke_i         (cke),
    .arst_n_i      (arst_n),
    .axil_awvalid_i(awvalid),
    .axil_awaddr_i (awaddr),
    .axil_wvalid_i (wvalid),
    .axil_wdata_i  (wdata),
    .axil_wstrb_i  (wstrb),
    .axil_bready_i (bready),
    .axil_arvalid_i(arvalid),
    .axil_araddr_i (araddr),
    .axil_rready_i (rready),
    .axil_awready_o(awready),
    .axil_wready_o (wready),
    .axil_bvalid_o (bvalid),
    .axil_bresp_o  (bresp),
    .axil_arready_o(arready),
    .axil_rvalid_o (rvalid),
    .axil_rdata_o  (rdata),
    .axil_rresp_o  (rresp)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
      $display("Timeout: no result after %0d clock cycles", MAX_CYCLES);
      $display("TB FAILED");
      $finish;
    end
  end

  // Two-stage history of rdata taken mid-cycle
  always @(negedge clk) begin
    rdata_prev <= rdata_now;
    rdata_now  <= rdata;
  end

  task automatic note_failure(input string what);
    $display("%0t: %s", $time, what);
    err_cnt++;
  endtask

  task automatic report_mismatch(input string sig, input axil_pkg::axil_data_t got,
                                 input axil_pkg::axil_data_t exp);
    $display("[ERROR] %0t %s got %h expected %h", $time, sig, got, exp);
    err_cnt++;
  endtask

  assert property (@(posedge clk) $rose(arst_n) |-> !bvalid && !rvalid)
    else note_failure("bvalid or rvalid set right after reset");
  assert property (@(posedge clk) disable iff (!arst_n)
    $past(arvalid && arready, 2) |-> rvalid && !$past(rvalid))
    else note_failure("rvalid did not rise two edges after read acceptance");
  assert property (@(posedge clk) disable iff (!arst_n)
    rvalid && !$past(rvalid) |-> $past(arvalid && arready, 2))
    else note_failure("rvalid rose without a read accepted two edges earlier");
  assert property (@(posedge clk) disable iff (!arst_n)
    $past(awvalid && awready && wvalid && wready) |-> bvalid && !$past(bvalid))
    else note_failure("bvalid did not rise one edge after write acceptance");
  assert property (@(posedge clk) disable iff (!arst_n)
    bvalid && !$past(bvalid) |-> $past(awvalid && awready && wvalid && wready))
    else note_failure("bvalid rose without an accepted write");
  assert property (@(posedge clk) disable iff (!arst_n)
    (rvalid || bvalid) |-> rresp == 2'b00 && bresp == 2'b00)
    else note_failure("response code is not OKAY");
  assert property (@(posedge clk) disable iff (!arst_n)
    rvalid && rready && !cmp_gt |-> rdata == exp_rdata)
    else report_mismatch("axil_rdata_o", $sampled(rdata), exp_rdata);
  assert property (@(posedge clk) disable iff (!arst_n)
    rvalid && rready && cmp_gt |-> rdata > exp_rdata)
    else note_failure("cycle counter did not increase");
  // Back-pressure holds the response and its data
  assert property (@(posedge clk) disable iff (!arst_n)
    $past(bvalid && !bready) |-> bvalid)
    else note_failure("bvalid dropped before bready");
  assert property (@(posedge clk) disable iff (!arst_n)
    $past(rvalid && !rready) |-> rvalid)
    else note_failure("rvalid dropped before rready");
  assert property (@(posedge clk) disable iff (!arst_n)
    $past(rvalid && !rready) |-> rdata == rdata_prev)
    else report_mismatch("axil_rdata_o", $sampled(rdata), rdata_prev);
  // Read wins a collision and the write waits
  assert property (@(posedge clk) disable iff (!arst_n)
    arvalid && awvalid |-> !awready && !wready)
    else note_failure("write accepted while a read was presented");

  function automatic axil_pkg::axil_data_t apply_strobe(input axil_pkg::axil_data_t old_v,
                                                        input axil_pkg::axil_data_t new_v,
                                                        input axil_pkg::axil_strb_t strb);
    axil_pkg::axil_data_t mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_v & ~mask) | (new_v & mask);
  endfunction

  function automatic axil_pkg::axil_addr_t ram_addr(input logic [7:0] idx);
    axil_pkg::axil_addr_t a;
    a = '0;
    a[`AXIL_IOB_RAM_SEL_BIT] = 1'b1;
    a[`AXIL_IOB_RAM_AW+1:2] = idx;
    return a;
  endfunction

  task automatic axil_write(input axil_pkg::axil_addr_t addr, input axil_pkg::axil_data_t data,
                            input axil_pkg::axil_strb_t strb, input int stall);
    @(posedge clk);
    awvalid <= 1'b1;
    awaddr  <= addr;
    wvalid  <= 1'b1;
    wdata   <= data;
    wstrb   <= strb;
    do @(negedge clk); while (!(awready && wready));
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    repeat (stall) @(posedge clk);
    bready <= 1'b1;
    do @(negedge clk); while (!bvalid);
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task automatic axil_read(input axil_pkg::axil_addr_t addr, input axil_pkg::axil_data_t exp,
                           input logic gt, input int stall, output axil_pkg::axil_data_t got);
    @(posedge clk);
    exp_rdata = exp;
    cmp_gt    = gt;
    arvalid <= 1'b1;
    araddr  <= addr;
    do @(negedge clk); while (!arready);
    @(posedge clk);
    arvalid <= 1'b0;
    repeat (stall) @(posedge clk);
    rready <= 1'b1;
    do @(negedge clk); while (!rvalid);
    got = rdata;
    @(posedge clk);
    rready <= 1'b0;
  endtask

  // Read and full-word write to one address in the same cycle
  task automatic collide(input axil_pkg::axil_addr_t addr, input axil_pkg::axil_data_t rd_exp,
                         input axil_pkg::axil_data_t wr_data);
    logic r_seen;
    logic b_seen;
    @(posedge clk);
    exp_rdata = rd_exp;
    cmp_gt    = 1'b0;
    arvalid <= 1'b1;
    araddr  <= addr;
    awvalid <= 1'b1;
    awaddr  <= addr;
    wvalid  <= 1'b1;
    wdata   <= wr_data;
    wstrb   <= 4'hF;
    rready  <= 1'b1;
    bready  <= 1'b1;
    do @(negedge clk); while (!arready);
    @(posedge clk);
    arvalid <= 1'b0;
    do @(negedge clk); while (!(awready && wready));
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    r_seen = 1'b0;
    b_seen = 1'b0;
    while (!(r_seen && b_seen)) begin
      @(negedge clk);
      r_seen = r_seen | rvalid;
      b_seen = b_seen | bvalid;
    end
    @(posedge clk);
    rready <= 1'b0;
    bready <= 1'b0;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (err_cnt == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d check errors", name, err_cnt - errs_before);
    end
  endtask

  initial begin
    axil_pkg::axil_data_t got;
    axil_pkg::axil_data_t prev;
    axil_pkg::axil_data_t d;
    axil_pkg::axil_strb_t s;
    axil_pkg::axil_addr_t a;
    logic [7:0]           idx_tbl [64];
    logic [7:0]           tmp;
    int                   sel;
    int                   j;
    int                   errs;
    void'($urandom(SEED));
    {awvalid, wvalid, bready, arvalid, rready} = '0;
    awaddr    = '0;
    wdata     = '0;
    wstrb     = '0;
    araddr    = '0;
    cke       = 1'b1;
    arst_n    = 1'b0;
    exp_rdata = '0;
    cmp_gt    = 1'b0;
    scr_model = '{default: '0};
    err_cnt   = 0;
    tests_run = 0;
    tests_bad = 0;
    cycle_cnt = 0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;

    errs = err_cnt;
    axil_read(`AXIL_IOB_CSR_ID, `AXIL_IOB_ID, 1'b0, 0, got);
    finish_test("reset_id", errs);

    errs = err_cnt;
    for (int i = 0; i < 16; i++) begin
      sel = $urandom_range(1, 0);
      a   = (sel == 0) ? `AXIL_IOB_CSR_SCR0 : `AXIL_IOB_CSR_SCR1;
      d   = $urandom;
      s   = ($urandom_range(1, 0) == 1) ? 4'hF : 4'($urandom_range(14, 1));
      axil_write(a, d, s, 0);
      scr_model[sel] = apply_strobe(scr_model[sel], d, s);
      axil_read(a, scr_model[sel], 1'b0, 0, got);
    end
    axil_write(`AXIL_IOB_CSR_SCR0, ~scr_model[0], 4'h0, 0);
    axil_read(`AXIL_IOB_CSR_SCR0, scr_model[0], 1'b0, 0, got);
    finish_test("scratch", errs);

    // Full words first so partial strobes never meet unwritten bytes
    errs = err_cnt;
    for (int i = 0; i < 64; i++) begin
      idx_tbl[i] = 8'($urandom_range(255, 0));
      d = $urandom;
      axil_write(ram_addr(idx_tbl[i]), d, 4'hF, 0);
      ram_model[idx_tbl[i]] = d;
    end
    for (int i = 0; i < 64; i++) begin
      d = $urandom;
      s = 4'($urandom_range(15, 0));
      axil_write(ram_addr(idx_tbl[i]), d, s, 0);
      ram_model[idx_tbl[i]] = apply_strobe(ram_model[idx_tbl[i]], d, s);
    end
    for (int i = 63; i > 0; i--) begin
      j = $urandom_range(i, 0);
      tmp = idx_tbl[j];
      idx_tbl[j] = idx_tbl[i];
      idx_tbl[i] = tmp;
    end
    for (int i = 0; i < 64; i++) begin
      axil_read(ram_addr(idx_tbl[i]), ram_model[idx_tbl[i]], 1'b0, 0, got);
    end
    for (int i = 0; i < 4; i++) begin
      a = {1'b0, 9'($urandom_range(511, 4)), 2'b00};
      axil_read(a, '0, 1'b0, 0, got);
    end
    finish_test("ram", errs);

    errs = err_cnt;
    axil_read(`AXIL_IOB_CSR_CYCLE, '0, 1'b1, 0, prev);
    repeat (10) @(posedge clk);
    axil_read(`AXIL_IOB_CSR_CYCLE, prev + 32'd10, 1'b1, 0, prev);
    axil_write(`AXIL_IOB_CSR_CYCLE, '0, 4'hF, 0);
    axil_write(`AXIL_IOB_CSR_ID, 32'hFFFF_FFFF, 4'hF, 0);
    axil_read(`AXIL_IOB_CSR_ID, `AXIL_IOB_ID, 1'b0, 0, got);
    axil_read(`AXIL_IOB_CSR_CYCLE, prev, 1'b1, 0, got);
    finish_test("counter", errs);

    // A read stall of two or more edges keeps rvalid waiting on rready
    errs = err_cnt;
    for (int i = 0; i < 8; i++) begin
      d = $urandom;
      if (i % 2 == 0) begin
        axil_write(`AXIL_IOB_CSR_SCR1, d, 4'hF, $urandom_range(7, 1));
        scr_model[1] = d;
        axil_read(`AXIL_IOB_CSR_SCR1, d, 1'b0, $urandom_range(7, 2), got);
      end else begin
        tmp = 8'($urandom_range(255, 0));
        axil_write(ram_addr(tmp), d, 4'hF, $urandom_range(7, 1));
        ram_model[tmp] = d;
        axil_read(ram_addr(tmp), d, 1'b0, $urandom_range(7, 2), got);
      end
    end
    finish_test("backpressure", errs);

    errs = err_cnt;
    d = $urandom;
    collide(`AXIL_IOB_CSR_SCR0, scr_model[0], d);
    scr_model[0] = d;
    axil_read(`AXIL_IOB_CSR_SCR0, d, 1'b0, 0, got);
    d = $urandom;
    collide(ram_addr(idx_tbl[0]), ram_model[idx_tbl[0]], d);
    ram_model[idx_tbl[0]] = d;
    axil_read(ram_addr(idx_tbl[0]), d, 1'b0, 0, got);
    finish_test("collision", errs);

    repeat (4) @(posedge clk);
    $display("Summary: %0d tests, %0d with errors, %0d check errors", tests_run, tests_bad,
             err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+source
source/axil_pkg.sv
source/iob_pkg.sv
source/axil2iob.sv
source/iob_decoder.sv
source/iob_csr_bank.sv
source/iob_ram.sv
source/axil_iob_top.sv
sim/axil_iob_tb.sv

// ==== Makefile ====
# Verilator build and run for the AXI4-Lite to IOb subsystem

VERILATOR  ?= verilator
TB_TOP     ?= axil_iob_tb
RTL_TOP    ?= axil_iob_top
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, the simulator exit code does not
run: build
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -q "^TB PASSED$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
